//--- stereo_dac.f
common/stereo_dac_pkg.sv
interp/interp_linear_2x.sv
logic/sample_fifo.sv
sdm/sigma_delta_stereo_dac.sv
logic/stereo_dac_output.sv
verif/stereo_dac_sva.sv
verif/tb_stereo_dac.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the stereo DAC testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_stereo_dac -f stereo_dac.f -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee "$LOG" \
    || { echo "Build or run error"; exit 1; }

grep -q "^Test failed$" "$LOG" && exit 1 \
    || grep -q "%Error" "$LOG" && exit 1 \
    || grep -q "^Test completed successfully$" "$LOG" || exit 1
exit 0

//--- verif/tb_stereo_dac.sv
// ----------------------------------------
// Stereo DAC output stage testbench
// ----------------------------------------

`timescale 1ns/1ps

module tb_stereo_dac
    import stereo_dac_pkg::*;
();

    localparam int OSR_DIV    = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int FEED_GAP   = 2 * OSR_DIV;
    localparam int SETTLE     = 256;
    localparam int WINDOW     = 2048;
    localparam int MID_WINDOW = 128;
    // Cycle budget per test
    localparam int T_QUIET    = 80;
    localparam int T_DC       = SETTLE + WINDOW + 40;
    localparam int T_MID      = 20 * FEED_GAP + 200 + 80 * FEED_GAP;
    localparam int T_HOLD     = 2 * WINDOW;
    localparam int T_OVF      = 400;
    localparam int T_RAND     = 5 * T_DC;
    localparam int TOTAL      = T_QUIET + T_DC + T_MID + T_HOLD + T_OVF + T_RAND;
    localparam int WATCHDOG   = TOTAL * 6 / 5;

    logic    sys_clk;
    logic    sys_rst;
    logic    strobe;
    sample_t in_l;
    sample_t in_r;
    logic    dac_l;
    logic    dac_r;
    logic    ovf;
    int      errors;
    int      checks;
    int      seed;

    // Port reset is the clock, port clk is the reset
    stereo_dac_output #(
        .OSR_DIV    (OSR_DIV),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .reset         (sys_clk),
        .clk           (sys_rst),
        .sample_in_rdy (strobe),
        .sample_in_l   (in_l),
        .sample_in_r   (in_r),
        .dac_out_l     (dac_l),
        .dac_out_r     (dac_r),
        .fifo_overflow (ovf)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    initial begin
        repeat (WATCHDOG) @(posedge sys_clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG);
        $display("Test failed");
        $finish;
    end

    task automatic check_value(input string name, input longint got, input longint exp,
                               input longint tol);
        checks++;
        if (got > exp + tol || got < exp - tol) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h (tolerance %0d)",
                     name, got, exp, tol);
        end
    endtask

    // Ones in n cycles for DC level x
    function automatic longint expected_ones(input longint x, input longint n);
        return ((x + 131072) * n) / 262144;
    endfunction

    task automatic apply_reset();
        @(negedge sys_clk);
        sys_rst = 1'b1;
        repeat (10) @(negedge sys_clk);
        sys_rst = 1'b0;
    endtask

    task automatic feed_pairs(input sample_t l, input sample_t r, input int count);
        repeat (count) begin
            @(negedge sys_clk);
            strobe = 1'b1;
            in_l   = l;
            in_r   = r;
            @(negedge sys_clk);
            strobe = 1'b0;
            repeat (FEED_GAP - 2) @(negedge sys_clk);
        end
    endtask

    task automatic count_ones(input int n, output int ones_l, output int ones_r);
        ones_l = 0;
        ones_r = 0;
        repeat (n) begin
            @(negedge sys_clk);
            ones_l += dac_l;
            ones_r += dac_r;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%s: PASS", name);
        end else begin
            $display("%s: FAIL (%0d errors)", name, errors - err_before);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_quiet();
        int e0;
        e0 = errors;
        @(negedge sys_clk);
        sys_rst = 1'b1;
        repeat (10) begin
            @(negedge sys_clk);
            check_value("dac_out_l", dac_l, 0, 0);
            check_value("dac_out_r", dac_r, 0, 0);
            check_value("fifo_overflow", ovf, 0, 0);
        end
        sys_rst = 1'b0;
        repeat (50) begin
            @(negedge sys_clk);
            check_value("dac_out_l", dac_l, 0, 0);
            check_value("dac_out_r", dac_r, 0, 0);
            check_value("fifo_overflow", ovf, 0, 0);
        end
        report_test("reset_quiet", e0);
    endtask

    task automatic dc_level(input string name, input sample_t l, input sample_t r);
        int e0;
        int ones_l;
        int ones_r;
        e0 = errors;
        fork
            feed_pairs(l, r, (SETTLE + WINDOW) / FEED_GAP + 1);
            begin
                repeat (SETTLE) @(negedge sys_clk);
                count_ones(WINDOW, ones_l, ones_r);
            end
        join
        check_value("dac_out_l ones", ones_l, expected_ones(l, WINDOW), 8);
        check_value("dac_out_r ones", ones_r, expected_ones(r, WINDOW), 8);
        report_test(name, e0);
    endtask

    task automatic test_midpoint();
        int     e0;
        int     waited;
        int     ones_l;
        int     ones_r;
        sample_t x;
        e0 = errors;
        x  = 18'sh18000;
        feed_pairs('0, '0, 20);
        // FIFO drains, modulator holds zero
        repeat (200) @(negedge sys_clk);
        fork
            feed_pairs(x, -x, 80);
            begin
                waited = 0;
                while (!i_dut.dac_rd && waited < 4 * OSR_DIV) begin
                    @(negedge sys_clk);
                    waited++;
                end
                if (!i_dut.dac_rd) begin
                    errors++;
                    $display("No FIFO read seen after the step input");
                end
                // First pair read after the step is halfway between zero and x
                check_value("fifo_dout left",
                            sample_t'(i_dut.fifo_dout[2*SAMPLE_W-1:SAMPLE_W]), x / 2, 0);
                check_value("fifo_dout right",
                            sample_t'(i_dut.fifo_dout[SAMPLE_W-1:0]), -x / 2, 0);
                @(negedge sys_clk);
                // One period of midpoint, rest at the new level
                count_ones(MID_WINDOW, ones_l, ones_r);
                check_value("dac_out_l mid ones", ones_l,
                            expected_ones(x / 2, OSR_DIV) +
                            expected_ones(x, MID_WINDOW - OSR_DIV), 4);
                check_value("dac_out_r mid ones", ones_r,
                            expected_ones(-x / 2, OSR_DIV) +
                            expected_ones(-x, MID_WINDOW - OSR_DIV), 4);
                count_ones(WINDOW, ones_l, ones_r);
                check_value("dac_out_l ones", ones_l, expected_ones(x, WINDOW), 8);
                check_value("dac_out_r ones", ones_r, expected_ones(-x, WINDOW), 8);
            end
        join
        report_test("interp_midpoint", e0);
    endtask

    task automatic test_underrun_hold();
        int e0;
        int ones_l;
        int ones_r;
        e0 = errors;
        repeat (2) begin
            count_ones(WINDOW, ones_l, ones_r);
            check_value("dac_out_l ones", ones_l, expected_ones(18'sh18000, WINDOW), 8);
            check_value("dac_out_r ones", ones_r, expected_ones(-18'sh18000, WINDOW), 8);
        end
        report_test("underrun_hold", e0);
    endtask

    task automatic test_overflow();
        int e0;
        e0 = errors;
        repeat (6) begin
            @(negedge sys_clk);
            strobe = 1'b1;
            in_l   = 18'sh00100;
            in_r   = 18'sh00200;
            @(negedge sys_clk);
            strobe = 1'b0;
            @(negedge sys_clk);
        end
        repeat (10) @(negedge sys_clk);
        check_value("fifo_overflow", ovf, 1, 0);
        repeat (100) @(negedge sys_clk);
        check_value("fifo_overflow", ovf, 1, 0);
        apply_reset();
        @(negedge sys_clk);
        check_value("fifo_overflow", ovf, 0, 0);
        report_test("overflow", e0);
    endtask

    task automatic test_random_dc();
        sample_t l;
        sample_t r;
        for (int i = 0; i < 5; i++) begin
            l = sample_t'($random(seed) % 32'sh18000);
            r = sample_t'($random(seed) % 32'sh18000);
            dc_level($sformatf("random_dc_%0d", i), l, r);
        end
    endtask

    initial begin
        sys_rst = 1'b1;
        strobe  = 1'b0;
        in_l    = '0;
        in_r    = '0;
        errors  = 0;
        checks  = 0;
        seed    = 32'hb38f_dde3;
        test_reset_quiet();
        dc_level("dc_level", 18'sh10000, -18'sh10000);
        test_midpoint();
        test_underrun_hold();
        test_overflow();
        test_random_dc();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verif/stereo_dac_sva.sv
// ----------------------------------------
// Assertions on DAC read strobe and outputs
// ----------------------------------------

`timescale 1ns/1ps

module stereo_dac_sva
    import stereo_dac_pkg::*;
(
    input logic       reset,
    input logic       clk,
    input logic       rd,
    input logic       empty,
    input dac_state_t state,
    input logic       dac_out_l,
    input logic       dac_out_r
);

    // Clock on reset, reset on clk
    a_rd_one_cycle: assert property (@(posedge reset) disable iff (clk) rd |=> !rd)
        else $error("rd held for more than one cycle");

    a_rd_not_empty: assert property (@(posedge reset) disable iff (clk) rd |-> !empty)
        else $error("rd raised while FIFO empty");

    a_idle_quiet: assert property (@(posedge reset) disable iff (clk)
        (state == IDLE) |-> (!dac_out_l && !dac_out_r))
        else $error("DAC output high in IDLE");

endmodule

bind sigma_delta_stereo_dac stereo_dac_sva i_sva (
    .reset     (reset),
    .clk       (clk),
    .rd        (rd),
    .empty     (empty),
    .state     (state),
    .dac_out_l (dac_out_l),
    .dac_out_r (dac_out_r)
);

//--- logic/stereo_dac_output.sv
// ----------------------------------------
// Stereo DAC output stage top level
// ----------------------------------------

`timescale 1ns/1ps

module stereo_dac_output
    import stereo_dac_pkg::*;
#(
    parameter int OSR_DIV    = 32,
    parameter int FIFO_DEPTH = 8
) (
    input  logic    reset,
    input  logic    clk,
    input  logic    sample_in_rdy,
    input  sample_t sample_in_l,
    input  sample_t sample_in_r,
    output logic    dac_out_l,
    output logic    dac_out_r,
    output logic    fifo_overflow
);

    logic    interp_rdy;
    sample_t interp_l;
    sample_t interp_r;
    pair_t   fifo_din;
    pair_t   fifo_dout;
    logic    fifo_empty;
    logic    dac_rd;

    interp_linear_2x i_interp (
        .reset         (reset),
        .clk           (clk),
        .sample_in_rdy (sample_in_rdy),
        .sample_in_l   (sample_in_l),
        .sample_in_r   (sample_in_r),
        .out_rdy       (interp_rdy),
        .out_l         (interp_l),
        .out_r         (interp_r)
    );

    // Left in the upper half
    assign fifo_din = {interp_l, interp_r};

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .reset    (reset),
        .clk      (clk),
        .wr       (interp_rdy),
        .data_in  (fifo_din),
        .rd       (dac_rd),
        .data_out (fifo_dout),
        .empty    (fifo_empty),
        .full     (),
        .overflow (fifo_overflow)
    );

    sigma_delta_stereo_dac #(
        .OSR_DIV (OSR_DIV)
    ) i_dac (
        .reset     (reset),
        .clk       (clk),
        .empty     (fifo_empty),
        .data_in   (fifo_dout),
        .rd        (dac_rd),
        .dac_out_l (dac_out_l),
        .dac_out_r (dac_out_r)
    );

endmodule

//--- sdm/sigma_delta_stereo_dac.sv
// ----------------------------------------
// Stereo second-order sigma-delta DAC
// Output-rate divider pulls pairs from FIFO
// ----------------------------------------

`timescale 1ns/1ps

module sigma_delta_stereo_dac
    import stereo_dac_pkg::*;
#(
    parameter int OSR_DIV = 32
) (
    input  logic  reset,
    input  logic  clk,
    input  logic  empty,
    input  pair_t data_in,
    output logic  rd,
    output logic  dac_out_l,
    output logic  dac_out_r
);

    localparam int   DIV_W  = (OSR_DIV > 1) ? $clog2(OSR_DIV) : 1;
    // Feedback levels are plus and minus full scale
    localparam acc_t FB_POS = acc_t'(1 << (SAMPLE_W - 1));
    localparam acc_t FB_NEG = -FB_POS;

    dac_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic             div_wrap;
    sample_t          cur_s  [2];
    acc_t             x_ext  [2];
    acc_t             fb     [2];
    acc_t             int1   [2];
    acc_t             int2   [2];
    acc_t             int1_n [2];
    acc_t             int2_n [2];
    logic [1:0]       bit_n;
    logic [1:0]       bit_q;

    // ----------------------------------------
    // Divider and read control
    // ----------------------------------------
    assign div_wrap = (div_cnt == DIV_W'(OSR_DIV - 1));

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            div_cnt <= '0;
            rd      <= 1'b0;
            state   <= IDLE;
        end else begin
            div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
            // Underrun keeps the current pair
            rd      <= div_wrap & ~empty;
            if (rd) begin
                state <= RUN;
            end
        end
    end

    // Pair latched with the read pulse
    always_ff @(posedge reset) begin
        if (rd) begin
            cur_s[0] <= data_in[2*SAMPLE_W-1:SAMPLE_W];
            cur_s[1] <= data_in[SAMPLE_W-1:0];
        end
    end

    // ----------------------------------------
    // Modulator, NTF (1 - z^-1)^2
    // ----------------------------------------
    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            bit_n[ch]  = ~int2[ch][ACC_W-1];
            fb[ch]     = bit_n[ch] ? FB_POS : FB_NEG;
            x_ext[ch]  = {{(ACC_W - SAMPLE_W){cur_s[ch][SAMPLE_W-1]}}, cur_s[ch]};
            int1_n[ch] = int1[ch] + x_ext[ch] - fb[ch];
            int2_n[ch] = int2[ch] + int1_n[ch] - fb[ch];
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            bit_q <= '0;
            for (int ch = 0; ch < 2; ch++) begin
                int1[ch] <= '0;
                int2[ch] <= '0;
            end
        end else if (state == RUN) begin
            for (int ch = 0; ch < 2; ch++) begin
                int1[ch]  <= int1_n[ch];
                int2[ch]  <= int2_n[ch];
                bit_q[ch] <= bit_n[ch];
            end
        end
    end

    assign dac_out_l = bit_q[0];
    assign dac_out_r = bit_q[1];

endmodule

//--- logic/sample_fifo.sv
// ----------------------------------------
// Show-ahead stereo sample FIFO
// ----------------------------------------

`timescale 1ns/1ps

module sample_fifo
    import stereo_dac_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic  reset,
    input  logic  clk,
    input  logic  wr,
    input  pair_t data_in,
    input  logic  rd,
    output pair_t data_out,
    output logic  empty,
    output logic  full,
    output logic  overflow
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    pair_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_wr    = wr & ~full;
    assign do_rd    = rd & ~empty;
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign data_out = mem[rd_ptr];

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until reset
            if (wr && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

//--- interp/interp_linear_2x.sv
// ----------------------------------------
// Stereo 2x linear interpolator
// Emits midpoint pair, then the new pair
// ----------------------------------------

`timescale 1ns/1ps

module interp_linear_2x
    import stereo_dac_pkg::*;
(
    input  logic    reset,
    input  logic    clk,
    input  logic    sample_in_rdy,
    input  sample_t sample_in_l,
    input  sample_t sample_in_r,
    output logic    out_rdy,
    output sample_t out_l,
    output sample_t out_r
);

    // Channel 0 is left, channel 1 is right
    sample_t                  in_s   [2];
    sample_t                  prev_s [2];
    sample_t                  new_s  [2];
    sample_t                  mid_s  [2];
    sample_t                  out_s  [2];
    logic signed [SAMPLE_W:0] sum_s  [2];
    logic [1:0]               phase;
    logic [1:0]               start;

    always_comb begin
        in_s[0] = sample_in_l;
        in_s[1] = sample_in_r;
        for (int ch = 0; ch < 2; ch++) begin
            // Strobe during the second phase is dropped
            start[ch] = sample_in_rdy & ~phase[ch];
            sum_s[ch] = {prev_s[ch][SAMPLE_W-1], prev_s[ch]} +
                        {in_s[ch][SAMPLE_W-1], in_s[ch]};
            // Halve with sign kept
            mid_s[ch] = sum_s[ch][SAMPLE_W:1];
        end
    end

    // ----------------------------------------
    // Control and history
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            out_rdy <= 1'b0;
            phase   <= '0;
            for (int ch = 0; ch < 2; ch++) begin
                prev_s[ch] <= '0;
            end
        end else begin
            out_rdy <= sample_in_rdy | (|phase);
            for (int ch = 0; ch < 2; ch++) begin
                phase[ch] <= start[ch];
                // New pair becomes history once it is sent
                if (phase[ch]) begin
                    prev_s[ch] <= new_s[ch];
                end
            end
        end
    end

    // Output data
    always_ff @(posedge reset) begin
        for (int ch = 0; ch < 2; ch++) begin
            if (start[ch]) begin
                new_s[ch] <= in_s[ch];
                out_s[ch] <= mid_s[ch];
            end else if (phase[ch]) begin
                out_s[ch] <= new_s[ch];
            end
        end
    end

    assign out_l = out_s[0];
    assign out_r = out_s[1];

endmodule

//--- common/stereo_dac_pkg.sv
// ----------------------------------------
// Stereo DAC shared widths and types
// ----------------------------------------

package stereo_dac_pkg;

    // ----------------------------------------
    // Sample path
    // ----------------------------------------

    // One signed audio sample
    localparam int SAMPLE_W = 18;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Stereo pair, left in upper half
    typedef logic [2*SAMPLE_W-1:0] pair_t;

    // ----------------------------------------
    // Modulator
    // ----------------------------------------

    // Integrator width, headroom above the sample
    localparam int ACC_W = 24;

    typedef logic signed [ACC_W-1:0] acc_t;

    // DAC control FSM
    typedef enum logic {
        IDLE,
        RUN
    } dac_state_t;

endpackage
